// ==== matmul_tile.f ====
src/tile_pkg.sv
src/ctrl_pkg.sv
src/array_ctrl_if.sv
src/weight_fifo.sv
src/act_skew.sv
src/systolic_array.sv
src/accumulator_bank.sv
src/tile_controller.sv
src/matmul_tile_top.sv
test/tb_matmul_tile.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_matmul_tile
FILELIST  ?= matmul_tile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps

.PHONY: sim clean

# pass only when the simulation prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_matmul_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matmul_tile;

    localparam int MUL_SIZE  = 4;
    localparam int DATA_W    = tile_pkg::DATA_W_DEF;
    localparam int ACC_W     = tile_pkg::ACC_W_DEF;
    localparam int ACC_DEPTH = tile_pkg::ACC_DEPTH_DEF;
    localparam int ADDR_W    = $clog2(ACC_DEPTH);
    localparam int ROWS_W    = $clog2(ACC_DEPTH + 1);
    // seven instructions of about 90 cycles each including readback plus margin for gaps
    localparam int TIMEOUT_CYCLES = 4000;

    typedef logic [MUL_SIZE*ACC_W-1:0]  acc_row_t;
    typedef logic [MUL_SIZE*DATA_W-1:0] data_row_t;

    logic              clk_i;
    logic              rst_n_i;
    logic              instr_valid_i;
    logic              instr_ready_o;
    ctrl_pkg::opcode_e instr_op_i;
    logic [ROWS_W-1:0] instr_rows_i;
    logic [ADDR_W-1:0] instr_base_i;
    logic              w_valid_i;
    logic              w_ready_o;
    data_row_t         w_data_i;
    logic              a_valid_i;
    logic              a_ready_o;
    data_row_t         a_data_i;
    logic [ADDR_W-1:0] rd_addr_i;
    acc_row_t          rd_data_o;
    logic              done_o;

    logic signed [DATA_W-1:0] w_tile [MUL_SIZE][MUL_SIZE];
    logic signed [DATA_W-1:0] act_vecs [ACC_DEPTH][MUL_SIZE];
    logic signed [DATA_W-1:0] w_keep [MUL_SIZE][MUL_SIZE];
    logic signed [DATA_W-1:0] act_keep [ACC_DEPTH][MUL_SIZE];
    acc_row_t                 model [ACC_DEPTH];

    int    seed;
    int    cycle_cnt = 0;
    string check_name;
    event  check_req;
    event  check_done;

    matmul_tile_top #(
        .MUL_SIZE(MUL_SIZE), .DATA_W(DATA_W), .ACC_W(ACC_W), .ACC_DEPTH(ACC_DEPTH)
    ) matmul_tile_top_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_ready_o(instr_ready_o),
        .instr_op_i(instr_op_i), .instr_rows_i(instr_rows_i), .instr_base_i(instr_base_i),
        .w_valid_i(w_valid_i), .w_ready_o(w_ready_o), .w_data_i(w_data_i),
        .a_valid_i(a_valid_i), .a_ready_o(a_ready_o), .a_data_i(a_data_i),
        .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o), .done_o(done_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout: the DUT did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    task automatic compare_row(input string name, input acc_row_t exp, input acc_row_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // column c of a result row is sum over k of act[k] * w[k][c]
    function automatic acc_row_t ref_row(input int vec);
        acc_row_t res;
        int       sum;
        res = '0;
        for (int c = 0; c < MUL_SIZE; c++) begin
            sum = 0;
            for (int k = 0; k < MUL_SIZE; k++) begin
                sum += int'(act_vecs[vec][k]) * int'(w_tile[k][c]);
            end
            res[c*ACC_W +: ACC_W] = sum[ACC_W-1:0];
        end
        return res;
    endfunction

    task automatic update_model(input ctrl_pkg::opcode_e op, input int rows, input int base);
        acc_row_t prod;
        int       addr;
        for (int i = 0; i < rows; i++) begin
            addr = (base + i) % ACC_DEPTH;
            prod = ref_row(i);
            if (op == ctrl_pkg::OP_MATMUL_ACC) begin
                for (int c = 0; c < MUL_SIZE; c++) begin
                    model[addr][c*ACC_W +: ACC_W] = model[addr][c*ACC_W +: ACC_W] +
                                                    prod[c*ACC_W +: ACC_W];
                end
            end else begin
                model[addr] = prod;
            end
        end
    endtask

    task automatic make_tile();
        for (int k = 0; k < MUL_SIZE; k++) begin
            for (int c = 0; c < MUL_SIZE; c++) begin
                w_tile[k][c] = DATA_W'($random(seed));
            end
        end
        for (int v = 0; v < ACC_DEPTH; v++) begin
            for (int k = 0; k < MUL_SIZE; k++) begin
                act_vecs[v][k] = DATA_W'($random(seed));
            end
        end
    endtask

    task automatic push_weights(input string name, input bit gaps);
        for (int k = 0; k < MUL_SIZE; k++) begin
            if (gaps) begin
                repeat ($random(seed) & 3) next_cycle();
            end
            w_valid_i = 1'b1;
            for (int c = 0; c < MUL_SIZE; c++) begin
                w_data_i[c*DATA_W +: DATA_W] = w_tile[k][c];
            end
            while (!w_ready_o) next_cycle();
            next_cycle();
            w_valid_i = 1'b0;
        end
        // a full FIFO refuses further rows
        compare_flag({name, " w_ready when full"}, 1'b0, w_ready_o);
    endtask

    task automatic send_instr(input ctrl_pkg::opcode_e op, input int rows, input int base);
        instr_valid_i = 1'b1;
        instr_op_i    = op;
        instr_rows_i  = ROWS_W'(rows);
        instr_base_i  = ADDR_W'(base);
        while (!instr_ready_o) next_cycle();
        next_cycle();
        instr_valid_i = 1'b0;
    endtask

    task automatic send_acts(input int rows, input bit gaps);
        for (int v = 0; v < rows; v++) begin
            if (gaps) begin
                repeat ($random(seed) & 3) next_cycle();
            end
            a_valid_i = 1'b1;
            for (int k = 0; k < MUL_SIZE; k++) begin
                a_data_i[k*DATA_W +: DATA_W] = act_vecs[v][k];
            end
            while (!a_ready_o) next_cycle();
            next_cycle();
            a_valid_i = 1'b0;
        end
    endtask

    // done is a single pulse and the DUT is ready again with it
    task automatic wait_done(input string name);
        while (!done_o) next_cycle();
        compare_flag({name, " ready with done"}, 1'b1, instr_ready_o);
        next_cycle();
        compare_flag({name, " done pulse width"}, 1'b0, done_o);
    endtask

    task automatic check_rows(input string name);
        check_name = name;
        -> check_req;
        @(check_done);
    endtask

    task automatic run_matmul(input string name, input ctrl_pkg::opcode_e op,
                              input int rows, input int base, input bit stalls);
        if (!stalls) begin
            push_weights(name, 1'b0);
        end
        send_instr(op, rows, base);
        compare_flag({name, " busy"}, 1'b0, instr_ready_o);
        if (stalls) begin
            // controller must hold off activations until the tile is in
            repeat (5) next_cycle();
            compare_flag({name, " a_ready while waiting"}, 1'b0, a_ready_o);
            push_weights(name, 1'b1);
        end
        send_acts(rows, stalls);
        wait_done(name);
        update_model(op, rows, base);
        check_rows(name);
    endtask

    // reads back every row so untouched neighbours are covered too
    initial begin
        rd_addr_i = '0;
        forever begin
            @(check_req);
            for (int r = 0; r < ACC_DEPTH; r++) begin
                rd_addr_i = ADDR_W'(r);
                next_cycle();
                compare_row($sformatf("%s row %0d", check_name, r), model[r], rd_data_o);
            end
            -> check_done;
        end
    end

    initial begin
        seed          = 6;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i    = ctrl_pkg::OP_NOP;
        instr_rows_i  = '0;
        instr_base_i  = '0;
        w_valid_i     = 1'b0;
        w_data_i      = '0;
        a_valid_i     = 1'b0;
        a_data_i      = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        compare_flag("reset instr_ready", 1'b1, instr_ready_o);
        compare_flag("reset done", 1'b0, done_o);
        compare_flag("reset w_ready", 1'b0, w_ready_o);
        compare_flag("reset a_ready", 1'b0, a_ready_o);

        // fills the whole bank including the last rows
        make_tile();
        run_matmul("fill all rows", ctrl_pkg::OP_MATMUL, ACC_DEPTH, 0, 1'b0);

        make_tile();
        w_keep   = w_tile;
        act_keep = act_vecs;
        run_matmul("overwrite eight rows", ctrl_pkg::OP_MATMUL, 8, 8, 1'b0);

        make_tile();
        run_matmul("accumulate eight rows", ctrl_pkg::OP_MATMUL_ACC, 8, 8, 1'b0);

        // same data as the plain overwrite but with back-pressure
        w_tile   = w_keep;
        act_vecs = act_keep;
        run_matmul("overwrite with stalls", ctrl_pkg::OP_MATMUL, 8, 8, 1'b1);

        make_tile();
        run_matmul("single row", ctrl_pkg::OP_MATMUL, 1, 3, 1'b0);

        make_tile();
        run_matmul("last rows", ctrl_pkg::OP_MATMUL_ACC, 5, ACC_DEPTH - 5, 1'b1);

        send_instr(ctrl_pkg::OP_NOP, 4, 10);
        compare_flag("nop done", 1'b1, done_o);
        wait_done("nop");
        check_rows("nop");

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/matmul_tile_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_tile_top #(
    parameter int MUL_SIZE  = tile_pkg::MUL_SIZE_DEF,
    parameter int DATA_W    = tile_pkg::DATA_W_DEF,
    parameter int ACC_W     = tile_pkg::ACC_W_DEF,
    parameter int ACC_DEPTH = tile_pkg::ACC_DEPTH_DEF
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           instr_valid_i,
    output logic                           instr_ready_o,
    input  ctrl_pkg::opcode_e              instr_op_i,
    input  logic [$clog2(ACC_DEPTH+1)-1:0] instr_rows_i,
    input  logic [$clog2(ACC_DEPTH)-1:0]   instr_base_i,
    input  logic                           w_valid_i,
    output logic                           w_ready_o,
    input  logic [MUL_SIZE*DATA_W-1:0]     w_data_i,
    input  logic                           a_valid_i,
    output logic                           a_ready_o,
    input  logic [MUL_SIZE*DATA_W-1:0]     a_data_i,
    input  logic [$clog2(ACC_DEPTH)-1:0]   rd_addr_i,
    output logic [MUL_SIZE*ACC_W-1:0]      rd_data_o,
    output logic                           done_o
);

    logic                       fifo_full;
    logic                       fifo_pop;
    logic                       a_take;
    logic [MUL_SIZE*DATA_W-1:0] w_row;
    logic [MUL_SIZE*DATA_W-1:0] skew_lanes;
    logic [MUL_SIZE*ACC_W-1:0]  col_sums;

    array_ctrl_if #(.MUL_SIZE(MUL_SIZE), .ACC_DEPTH(ACC_DEPTH)) ctl_if ();

    tile_controller #(.MUL_SIZE(MUL_SIZE), .ACC_DEPTH(ACC_DEPTH)) tile_controller_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_ready_o(instr_ready_o),
        .instr_op_i(instr_op_i), .instr_rows_i(instr_rows_i), .instr_base_i(instr_base_i),
        .fifo_full_i(fifo_full), .pop_o(fifo_pop),
        .a_valid_i(a_valid_i), .a_ready_o(a_ready_o), .a_take_o(a_take),
        .ctl(ctl_if.ctrl), .done_o(done_o)
    );

    weight_fifo #(.MUL_SIZE(MUL_SIZE), .DATA_W(DATA_W)) weight_fifo_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .w_valid_i(w_valid_i), .w_ready_o(w_ready_o), .w_data_i(w_data_i),
        .pop_i(fifo_pop), .full_o(fifo_full), .row_o(w_row)
    );

    act_skew #(.MUL_SIZE(MUL_SIZE), .DATA_W(DATA_W)) act_skew_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .ctl(ctl_if.array),
        .a_data_i(a_data_i), .a_take_i(a_take), .lanes_o(skew_lanes)
    );

    systolic_array #(.MUL_SIZE(MUL_SIZE), .DATA_W(DATA_W), .ACC_W(ACC_W)) systolic_array_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .ctl(ctl_if.array),
        .w_row_i(w_row), .act_i(skew_lanes), .sums_o(col_sums)
    );

    accumulator_bank #(
        .MUL_SIZE(MUL_SIZE), .ACC_W(ACC_W), .ACC_DEPTH(ACC_DEPTH)
    ) accumulator_bank_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .ctl(ctl_if.acc),
        .sums_i(col_sums), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o)
    );

endmodule

`default_nettype wire

// ==== src/tile_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_controller #(
    parameter int MUL_SIZE  = tile_pkg::MUL_SIZE_DEF,
    parameter int ACC_DEPTH = tile_pkg::ACC_DEPTH_DEF
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             instr_valid_i,
    output logic                             instr_ready_o,
    input  ctrl_pkg::opcode_e                instr_op_i,
    input  logic [$clog2(ACC_DEPTH+1)-1:0]   instr_rows_i,
    input  logic [$clog2(ACC_DEPTH)-1:0]     instr_base_i,
    input  logic                             fifo_full_i,
    output logic                             pop_o,
    input  logic                             a_valid_i,
    output logic                             a_ready_o,
    output logic                             a_take_o,
    array_ctrl_if.ctrl                       ctl,
    output logic                             done_o
);

    localparam int ADDR_W = $clog2(ACC_DEPTH);
    localparam int ROWS_W = $clog2(ACC_DEPTH + 1);
    localparam int CNT_W  = $clog2(ACC_DEPTH + 2*MUL_SIZE + 1);
    localparam int LD_W   = $clog2(MUL_SIZE);

    ctrl_pkg::ctrl_state_e state_q;
    ctrl_pkg::out_phase_e  phase;

    logic [ROWS_W-1:0] rows_q;
    logic [ADDR_W-1:0] base_q;
    logic              acc_add_q;
    logic [LD_W-1:0]   ld_cnt_q;
    logic [ROWS_W-1:0] vec_cnt_q;
    logic [CNT_W-1:0]  step_q;
    logic [CNT_W-1:0]  out_idx;
    logic [CNT_W-1:0]  last_step;
    logic              running;

    assign instr_ready_o = (state_q == ctrl_pkg::IDLE);
    assign a_ready_o     = (state_q == ctrl_pkg::COMPUTE);
    assign a_take_o      = a_ready_o & a_valid_i;
    assign pop_o         = (state_q == ctrl_pkg::LOAD_WEIGHTS);
    assign running       = (state_q == ctrl_pkg::COMPUTE) || (state_q == ctrl_pkg::DRAIN);

    // first product reaches the bottom of column 0 after MUL_SIZE+1 steps
    assign out_idx   = step_q - CNT_W'(MUL_SIZE + 1);
    // last write is lane MUL_SIZE-1 of the last vector
    assign last_step = CNT_W'(rows_q) + CNT_W'(2*MUL_SIZE - 1);

    assign ctl.load_weights = pop_o;
    assign ctl.advance      = a_take_o | (state_q == ctrl_pkg::DRAIN);
    assign ctl.wr_en        = ctl.advance & (phase != ctrl_pkg::NO_OUTPUT);
    assign ctl.wr_addr      = base_q + out_idx[ADDR_W-1:0];
    assign ctl.acc_add      = acc_add_q;

    always_comb begin
        if (!running || step_q < CNT_W'(MUL_SIZE + 1)) begin
            phase = ctrl_pkg::NO_OUTPUT;
        end else if (out_idx < CNT_W'(MUL_SIZE - 1)) begin
            phase = ctrl_pkg::PARTIAL_OUTPUT;
        end else if (out_idx < CNT_W'(rows_q)) begin
            phase = ctrl_pkg::FULL_OUTPUT;
        end else begin
            phase = ctrl_pkg::REVERSE_PARTIAL;
        end
    end

    // lane c holds vector out_idx-c, live while that vector exists
    always_comb begin
        for (int c = 0; c < MUL_SIZE; c++) begin
            case (phase)
                ctrl_pkg::PARTIAL_OUTPUT: begin
                    ctl.lane_mask[c] = (CNT_W'(c) <= out_idx) &&
                                       ((out_idx - CNT_W'(c)) < CNT_W'(rows_q));
                end
                ctrl_pkg::FULL_OUTPUT: begin
                    ctl.lane_mask[c] = 1'b1;
                end
                ctrl_pkg::REVERSE_PARTIAL: begin
                    ctl.lane_mask[c] = (out_idx - CNT_W'(c)) < CNT_W'(rows_q);
                end
                default: begin
                    ctl.lane_mask[c] = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ctrl_pkg::IDLE;
            rows_q    <= '0;
            base_q    <= '0;
            acc_add_q <= 1'b0;
            ld_cnt_q  <= '0;
            vec_cnt_q <= '0;
            step_q    <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                ctrl_pkg::IDLE: begin
                    if (instr_valid_i) begin
                        if (instr_op_i == ctrl_pkg::OP_NOP) begin
                            done_o <= 1'b1;
                        end else begin
                            rows_q    <= instr_rows_i;
                            base_q    <= instr_base_i;
                            acc_add_q <= (instr_op_i == ctrl_pkg::OP_MATMUL_ACC);
                            state_q   <= ctrl_pkg::WAIT_WEIGHTS;
                        end
                    end
                end
                ctrl_pkg::WAIT_WEIGHTS: begin
                    if (fifo_full_i) begin
                        ld_cnt_q <= '0;
                        state_q  <= ctrl_pkg::LOAD_WEIGHTS;
                    end
                end
                ctrl_pkg::LOAD_WEIGHTS: begin
                    ld_cnt_q <= ld_cnt_q + 1'b1;
                    if (ld_cnt_q == LD_W'(MUL_SIZE - 1)) begin
                        vec_cnt_q <= '0;
                        step_q    <= '0;
                        state_q   <= ctrl_pkg::COMPUTE;
                    end
                end
                ctrl_pkg::COMPUTE: begin
                    // a_valid_i low freezes everything
                    if (a_take_o) begin
                        vec_cnt_q <= vec_cnt_q + 1'b1;
                        step_q    <= step_q + 1'b1;
                        if (vec_cnt_q == rows_q - 1'b1) begin
                            state_q <= ctrl_pkg::DRAIN;
                        end
                    end
                end
                ctrl_pkg::DRAIN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == last_step) begin
                        done_o  <= 1'b1;
                        state_q <= ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= ctrl_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/accumulator_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module accumulator_bank #(
    parameter int MUL_SIZE  = tile_pkg::MUL_SIZE_DEF,
    parameter int ACC_W     = tile_pkg::ACC_W_DEF,
    parameter int ACC_DEPTH = tile_pkg::ACC_DEPTH_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    array_ctrl_if.acc                    ctl,
    input  logic [MUL_SIZE*ACC_W-1:0]    sums_i,
    input  logic [$clog2(ACC_DEPTH)-1:0] rd_addr_i,
    output logic [MUL_SIZE*ACC_W-1:0]    rd_data_o
);

    localparam int ADDR_W = $clog2(ACC_DEPTH);

    for (genvar c = 0; c < MUL_SIZE; c++) begin : g_lane
        logic [ACC_W-1:0]  mem [ACC_DEPTH];
        logic [ADDR_W-1:0] lane_addr;
        logic [ACC_W-1:0]  lane_sum;
        logic [ACC_W-1:0]  rd_q;

        // column c lags column 0 by c steps, undo that here
        assign lane_addr = ctl.wr_addr - ADDR_W'(c);
        assign lane_sum  = sums_i[c*ACC_W +: ACC_W];

        always_ff @(posedge clk_i) begin
            if (ctl.wr_en && ctl.lane_mask[c]) begin
                mem[lane_addr] <= ctl.acc_add ? mem[lane_addr] + lane_sum : lane_sum;
            end
        end

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rd_q <= '0;
            end else begin
                rd_q <= mem[rd_addr_i];
            end
        end

        assign rd_data_o[c*ACC_W +: ACC_W] = rd_q;
    end

endmodule

`default_nettype wire

// ==== src/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_array #(
    parameter int MUL_SIZE = tile_pkg::MUL_SIZE_DEF,
    parameter int DATA_W   = tile_pkg::DATA_W_DEF,
    parameter int ACC_W    = tile_pkg::ACC_W_DEF
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    array_ctrl_if.array                ctl,
    input  logic [MUL_SIZE*DATA_W-1:0] w_row_i,
    input  logic [MUL_SIZE*DATA_W-1:0] act_i,
    output logic [MUL_SIZE*ACC_W-1:0]  sums_o
);

    logic signed [DATA_W-1:0] w_q [MUL_SIZE][MUL_SIZE];
    logic signed [DATA_W-1:0] a_q [MUL_SIZE][MUL_SIZE];
    logic signed [ACC_W-1:0]  p_q [MUL_SIZE][MUL_SIZE];

    // rows enter at the bottom and move up one row per pop,
    // so the first popped row settles in grid row 0
    always_ff @(posedge clk_i) begin
        if (ctl.load_weights) begin
            for (int r = 0; r < MUL_SIZE - 1; r++) begin
                for (int c = 0; c < MUL_SIZE; c++) begin
                    w_q[r][c] <= w_q[r+1][c];
                end
            end
            for (int c = 0; c < MUL_SIZE; c++) begin
                w_q[MUL_SIZE-1][c] <= w_row_i[c*DATA_W +: DATA_W];
            end
        end
    end

    for (genvar r = 0; r < MUL_SIZE; r++) begin : g_row
        for (genvar c = 0; c < MUL_SIZE; c++) begin : g_col
            logic signed [DATA_W-1:0] a_in;
            logic signed [ACC_W-1:0]  p_in;
            logic signed [ACC_W-1:0]  prod;

            if (c == 0) begin : g_left
                assign a_in = act_i[r*DATA_W +: DATA_W];
            end else begin : g_inner
                assign a_in = a_q[r][c-1];
            end

            if (r == 0) begin : g_top
                assign p_in = '0;
            end else begin : g_below
                assign p_in = p_q[r-1][c];
            end

            // operands sign-extend to ACC_W before the multiply
            assign prod = ACC_W'(a_in) * ACC_W'(w_q[r][c]);

            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    a_q[r][c] <= '0;
                    p_q[r][c] <= '0;
                end else if (ctl.advance) begin
                    a_q[r][c] <= a_in;
                    p_q[r][c] <= p_in + prod;
                end
            end
        end
    end

    for (genvar c = 0; c < MUL_SIZE; c++) begin : g_out
        assign sums_o[c*ACC_W +: ACC_W] = p_q[MUL_SIZE-1][c];
    end

endmodule

`default_nettype wire

// ==== src/act_skew.sv ====
`timescale 1ns/1ps
`default_nettype none

module act_skew #(
    parameter int MUL_SIZE = tile_pkg::MUL_SIZE_DEF,
    parameter int DATA_W   = tile_pkg::DATA_W_DEF
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    array_ctrl_if.array                ctl,
    input  logic [MUL_SIZE*DATA_W-1:0] a_data_i,
    input  logic                       a_take_i,
    output logic [MUL_SIZE*DATA_W-1:0] lanes_o
);

    // lane i runs through i+1 stages, so it trails lane 0 by i steps
    for (genvar i = 0; i < MUL_SIZE; i++) begin : g_lane
        logic [DATA_W-1:0] sr_q [i+1];

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                for (int k = 0; k <= i; k++) begin
                    sr_q[k] <= '0;
                end
            end else if (ctl.advance) begin
                // bubbles enter as zeros
                sr_q[0] <= a_take_i ? a_data_i[i*DATA_W +: DATA_W] : '0;
                for (int k = 1; k <= i; k++) begin
                    sr_q[k] <= sr_q[k-1];
                end
            end
        end

        assign lanes_o[i*DATA_W +: DATA_W] = sr_q[i];
    end

endmodule

`default_nettype wire

// ==== src/weight_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_fifo #(
    parameter int MUL_SIZE = tile_pkg::MUL_SIZE_DEF,
    parameter int DATA_W   = tile_pkg::DATA_W_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         w_valid_i,
    output logic                         w_ready_o,
    input  logic [MUL_SIZE*DATA_W-1:0]   w_data_i,
    input  logic                         pop_i,
    output logic                         full_o,
    output logic [MUL_SIZE*DATA_W-1:0]   row_o
);

    localparam int PTR_W = $clog2(MUL_SIZE);
    localparam int CNT_W = $clog2(MUL_SIZE + 1);

    logic [MUL_SIZE*DATA_W-1:0] mem [MUL_SIZE];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [CNT_W-1:0]           count_q;
    logic [CNT_W-1:0]           count_next;
    logic                       w_ready_q;
    logic                       push;

    // depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MUL_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push       = w_valid_i & w_ready_q;
    assign count_next = count_q + CNT_W'(push) - CNT_W'(pop_i);
    assign full_o     = (count_q == CNT_W'(MUL_SIZE));
    assign w_ready_o  = w_ready_q;
    assign row_o      = mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            w_ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q   <= count_next;
            // registered ready, equal to not full once out of reset
            w_ready_q <= (count_next != CNT_W'(MUL_SIZE));
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= w_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/array_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface array_ctrl_if #(
    parameter int MUL_SIZE  = tile_pkg::MUL_SIZE_DEF,
    parameter int ACC_DEPTH = tile_pkg::ACC_DEPTH_DEF
) ();

    logic                         load_weights;
    logic                         advance;
    logic                         wr_en;
    logic [$clog2(ACC_DEPTH)-1:0] wr_addr;
    logic [MUL_SIZE-1:0]          lane_mask;
    logic                         acc_add;

    modport ctrl  (output load_weights, advance, wr_en, wr_addr, lane_mask, acc_add);
    modport array (input load_weights, advance);
    modport acc   (input wr_en, wr_addr, lane_mask, acc_add);

endinterface

`default_nettype wire

// ==== src/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // instruction opcodes
    typedef enum logic [1:0] {
        OP_NOP        = 2'd0,
        OP_MATMUL     = 2'd1,
        OP_MATMUL_ACC = 2'd2
    } opcode_e;

    // instruction sequencing
    typedef enum logic [2:0] {
        IDLE,
        WAIT_WEIGHTS,
        LOAD_WEIGHTS,
        COMPUTE,
        DRAIN
    } ctrl_state_e;

    // shape of the write lane mask
    typedef enum logic [1:0] {
        NO_OUTPUT,
        PARTIAL_OUTPUT,
        FULL_OUTPUT,
        REVERSE_PARTIAL
    } out_phase_e;

endpackage

`default_nettype wire

// ==== src/tile_pkg.sv ====
`default_nettype none

package tile_pkg;

    // array is MUL_SIZE x MUL_SIZE processing elements
    localparam int MUL_SIZE_DEF = 4;

    // signed weights and activations
    localparam int DATA_W_DEF = 8;

    // accumulator lane width
    // 16 product bits plus headroom for summing several tiles
    localparam int ACC_W_DEF = 20;

    // rows per accumulator lane, power of two
    localparam int ACC_DEPTH_DEF = 32;

endpackage

`default_nettype wire
